//--- rtl/i2c_host_consts.svh
`ifndef I2C_HOST_CONSTS_SVH
`define I2C_HOST_CONSTS_SVH

// wishbone register map of the i2c master core
`define I2C_REG_STATUS      3'd0
`define I2C_REG_ADDR        3'd2
`define I2C_REG_CMD         3'd3
`define I2C_REG_DATA        3'd4

// command register values
`define I2C_CMD_START_WRITE 8'h05 // start + write
`define I2C_CMD_START_READ  8'h03 // start + read
`define I2C_CMD_WRITE       8'h04
`define I2C_CMD_READ        8'h02
`define I2C_CMD_STOP        8'h10

// status register bits
`define I2C_ST_BUSY         0
`define I2C_ST_NACK         3 // missed ack from slave

// host control word layout
`define CW_START            0
`define CW_READ             1
`define CW_WRITE            2
`define CW_ADDR_LSB         4
`define CW_ADDR_MSB         10
`define CW_LEN_LSB          11
`define CW_LEN_MSB          14

`endif

//--- rtl/i2c_host_pkg.sv
package i2c_host_pkg;

	// command captured from the host, held for a whole transaction
	typedef struct packed {
		logic [6:0]  addr; // 7-bit slave address
		logic [3:0]  len;  // byte count, 1 to 4
		logic [31:0] data; // write payload, low byte first
	} host_cmd_t;

	// one wishbone request towards the core
	typedef struct packed {
		logic [2:0] adr;
		logic [7:0] dat;
		logic       we;
		logic       stb; // one cycle per access
		logic       cyc;
	} wb_req_t;

	typedef enum logic [1:0] {
		OP_IDLE,
		OP_READ,
		OP_WRITE,
		OP_DONE
	} host_op_e;

	typedef enum logic [3:0] {
		RD_IDLE, RD_ADDR, RD_START, RD_WAIT_HI,
		RD_WAIT_LO, RD_STOP, RD_FETCH, RD_NACK_STOP
	} rd_state_e;

	typedef enum logic [3:0] {
		WR_IDLE, WR_ADDR, WR_FILL, WR_START,
		WR_WAIT_HI, WR_WAIT_LO, WR_STOP, WR_NACK_STOP
	} wr_state_e;

endpackage

//--- rtl/i2c_read_seq.sv
`include "i2c_host_consts.svh"

module i2c_read_seq import i2c_host_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      go_i,      // one-cycle launch
	input  host_cmd_t cmd_i,     // held by the controller while busy
	input  logic [7:0] wb_dat_i,
	input  logic      wb_ack_i,
	output wb_req_t   wb_o,
	output logic      fin_o,
	output logic      nack_o
);

	rd_state_e  state;
	wb_req_t    req;
	logic [3:0] sent_cnt;  // bytes the core has clocked in
	logic [3:0] fetch_cnt; // read fifo pops issued

	// register write access
	function automatic wb_req_t bus_wr(input logic [2:0] adr, input logic [7:0] dat);
		wb_req_t r;
		r.adr = adr;
		r.dat = dat;
		r.we  = 1'b1;
		r.stb = 1'b1;
		r.cyc = 1'b1;
		return r;
	endfunction

	// register read access, dat unused
	function automatic wb_req_t bus_rd(input logic [2:0] adr);
		wb_req_t r;
		r.adr = adr;
		r.dat = 8'h00;
		r.we  = 1'b0;
		r.stb = 1'b1;
		r.cyc = 1'b1;
		return r;
	endfunction

	wire st_busy = wb_dat_i[`I2C_ST_BUSY];
	wire st_nack = wb_dat_i[`I2C_ST_NACK];

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state     <= RD_IDLE;
			req       <= '0;
			sent_cnt  <= 4'd0;
			fetch_cnt <= 4'd0;
			fin_o     <= 1'b0;
			nack_o    <= 1'b0;
		end else begin
			req.stb <= 1'b0; // strobe lasts one cycle, rest held until ack
			fin_o   <= 1'b0;
			case (state)
				RD_IDLE: if (go_i) begin
					req       <= bus_wr(`I2C_REG_ADDR, {1'b0, cmd_i.addr});
					sent_cnt  <= 4'd0;
					fetch_cnt <= 4'd0;
					state     <= RD_ADDR;
				end
				RD_ADDR: if (wb_ack_i) begin
					req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_START_READ);
					state <= RD_START;
				end
				RD_START: if (wb_ack_i) begin // command taken, start polling
					req   <= bus_rd(`I2C_REG_STATUS);
					state <= RD_WAIT_HI;
				end
				RD_WAIT_HI: if (wb_ack_i) begin
					if (st_busy) begin
						req      <= bus_rd(`I2C_REG_STATUS);
						sent_cnt <= sent_cnt + 4'd1; // byte in flight
						state    <= RD_WAIT_LO;
					end else if (st_nack) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_STOP);
						state <= RD_NACK_STOP;
					end else
						req <= bus_rd(`I2C_REG_STATUS); // not busy yet
				end
				RD_WAIT_LO: if (wb_ack_i) begin
					if (st_busy)
						req <= bus_rd(`I2C_REG_STATUS);
					else if (st_nack) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_STOP);
						state <= RD_NACK_STOP;
					end else if (sent_cnt == cmd_i.len) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_STOP);
						state <= RD_STOP;
					end else begin
						// restart for the next byte
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_READ);
						state <= RD_START;
					end
				end
				RD_STOP: if (wb_ack_i) begin // drain the read fifo
					req       <= bus_rd(`I2C_REG_DATA);
					fetch_cnt <= 4'd1;
					state     <= RD_FETCH;
				end
				RD_FETCH: if (wb_ack_i) begin
					if (fetch_cnt == cmd_i.len) begin
						req    <= '0; // bytes are dropped, only popped
						fin_o  <= 1'b1;
						nack_o <= 1'b0;
						state  <= RD_IDLE;
					end else begin
						req       <= bus_rd(`I2C_REG_DATA);
						fetch_cnt <= fetch_cnt + 4'd1;
					end
				end
				RD_NACK_STOP: if (wb_ack_i) begin // stop acked, no fetch
					req    <= '0;
					fin_o  <= 1'b1;
					nack_o <= 1'b1;
					state  <= RD_IDLE;
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	assign wb_o = req;

endmodule

//--- rtl/i2c_write_seq.sv
`include "i2c_host_consts.svh"

module i2c_write_seq import i2c_host_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      go_i,
	input  host_cmd_t cmd_i,
	input  logic [7:0] wb_dat_i, // status on poll acks
	input  logic      wb_ack_i,
	output wb_req_t   wb_o,
	output logic      fin_o,
	output logic      nack_o
);

	wr_state_e   state;
	wb_req_t     req;
	logic [31:0] shreg;    // payload, next byte in [7:0]
	logic [3:0]  fill_cnt; // bytes pushed into write fifo
	logic [3:0]  sent_cnt; // bytes sent on the i2c bus

	function automatic wb_req_t bus_wr(input logic [2:0] adr, input logic [7:0] dat);
		wb_req_t r;
		r.adr = adr;
		r.dat = dat;
		r.we  = 1'b1;
		r.stb = 1'b1;
		r.cyc = 1'b1;
		return r;
	endfunction

	function automatic wb_req_t bus_rd(input logic [2:0] adr);
		wb_req_t r;
		r.adr = adr;
		r.dat = 8'h00;
		r.we  = 1'b0;
		r.stb = 1'b1;
		r.cyc = 1'b1;
		return r;
	endfunction

	wire st_busy = wb_dat_i[`I2C_ST_BUSY];
	wire st_nack = wb_dat_i[`I2C_ST_NACK];

	// payload shift register, loaded on go
	always_ff @(posedge clk) begin
		if (state == WR_IDLE && go_i)
			shreg <= cmd_i.data;
		else if ((state == WR_ADDR || state == WR_FILL) && wb_ack_i && fill_cnt != cmd_i.len)
			shreg <= {8'h00, shreg[31:8]}; // byte leaves with this push
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state    <= WR_IDLE;
			req      <= '0;
			fill_cnt <= 4'd0;
			sent_cnt <= 4'd0;
			fin_o    <= 1'b0;
			nack_o   <= 1'b0;
		end else begin
			req.stb <= 1'b0;
			fin_o   <= 1'b0;
			case (state)
				WR_IDLE: if (go_i) begin
					req      <= bus_wr(`I2C_REG_ADDR, {1'b0, cmd_i.addr}); // top bit zero
					fill_cnt <= 4'd0;
					sent_cnt <= 4'd0;
					state    <= WR_ADDR;
				end
				// address acked, then one push per byte
				WR_ADDR, WR_FILL: if (wb_ack_i) begin
					if (fill_cnt == cmd_i.len) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_START_WRITE);
						state <= WR_START;
					end else begin
						req      <= bus_wr(`I2C_REG_DATA, shreg[7:0]);
						fill_cnt <= fill_cnt + 4'd1;
						state    <= WR_FILL;
					end
				end
				WR_START: if (wb_ack_i) begin
					req   <= bus_rd(`I2C_REG_STATUS);
					state <= WR_WAIT_HI;
				end
				WR_WAIT_HI: if (wb_ack_i) begin
					if (st_busy) begin
						req      <= bus_rd(`I2C_REG_STATUS);
						sent_cnt <= sent_cnt + 4'd1;
						state    <= WR_WAIT_LO;
					end else if (st_nack) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_STOP);
						state <= WR_NACK_STOP;
					end else
						req <= bus_rd(`I2C_REG_STATUS);
				end
				WR_WAIT_LO: if (wb_ack_i) begin
					if (st_busy)
						req <= bus_rd(`I2C_REG_STATUS); // still shifting out
					else if (st_nack) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_STOP);
						state <= WR_NACK_STOP;
					end else if (sent_cnt == cmd_i.len) begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_STOP);
						state <= WR_STOP;
					end else begin
						req   <= bus_wr(`I2C_REG_CMD, `I2C_CMD_WRITE); // next byte from fifo
						state <= WR_START;
					end
				end
				WR_STOP, WR_NACK_STOP: if (wb_ack_i) begin
					req    <= '0;
					fin_o  <= 1'b1;
					nack_o <= (state == WR_NACK_STOP);
					state  <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	assign wb_o = req;

endmodule

//--- rtl/i2c_host_ctrl.sv
`include "i2c_host_consts.svh"

module i2c_host_ctrl import i2c_host_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] control_word_i,
	input  logic [31:0] data_word_i,
	input  wb_req_t     rd_req_i,
	input  wb_req_t     wr_req_i,
	input  logic        rd_fin_i,
	input  logic        wr_fin_i,
	input  logic        rd_nack_i,
	input  logic        wr_nack_i,
	output logic        rd_go_o,
	output logic        wr_go_o,
	output host_cmd_t   cmd_o,
	output wb_req_t     wb_o,
	output logic        done_o,
	output logic        busy_o,
	output logic        nack_o
);

	host_op_e op;

	// control word fields
	wire cw_start = control_word_i[`CW_START];
	wire cw_read  = control_word_i[`CW_READ];
	wire cw_write = control_word_i[`CW_WRITE];

	always_ff @(posedge clk) begin
		if (!nrst) begin
			op      <= OP_IDLE;
			rd_go_o <= 1'b0;
			wr_go_o <= 1'b0;
			nack_o  <= 1'b0;
		end else begin
			rd_go_o <= 1'b0;
			wr_go_o <= 1'b0;
			case (op)
				OP_IDLE: if (cw_start && (cw_read || cw_write)) begin
					nack_o <= 1'b0; // cleared by each accepted command
					if (cw_read) begin // read wins over write
						op      <= OP_READ;
						rd_go_o <= 1'b1;
					end else begin
						op      <= OP_WRITE;
						wr_go_o <= 1'b1;
					end
				end
				OP_READ: if (rd_fin_i) begin
					op     <= OP_DONE;
					nack_o <= rd_nack_i;
				end
				OP_WRITE: if (wr_fin_i) begin
					op     <= OP_DONE;
					nack_o <= wr_nack_i;
				end
				default: op <= OP_IDLE; // done lasts one cycle
			endcase
		end
	end

	// payload only, held through the transaction
	always_ff @(posedge clk)
		if (op == OP_IDLE)
			cmd_o <= {control_word_i[`CW_ADDR_MSB:`CW_ADDR_LSB],
				control_word_i[`CW_LEN_MSB:`CW_LEN_LSB], data_word_i};

	always_comb begin
		case (op)
			OP_READ:  wb_o = rd_req_i;
			OP_WRITE: wb_o = wr_req_i;
			default:  wb_o = '0;
		endcase
	end

	assign busy_o = (op == OP_READ) || (op == OP_WRITE);
	assign done_o = (op == OP_DONE);

endmodule

//--- rtl/i2c_main_controller.sv
module i2c_main_controller import i2c_host_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] control_word_i,
	input  logic [31:0] data_word_i,
	input  logic [7:0]  wb_dat_i,
	input  logic        wb_ack_i,
	output wb_req_t     wb_o,
	output logic        done_o,
	output logic        busy_o,
	output logic        nack_o
);

	host_cmd_t cmd;     // latched command, shared by both sequencers
	wb_req_t   rd_req;
	wb_req_t   wr_req;
	logic      rd_go, wr_go;
	logic      rd_fin, wr_fin;
	logic      rd_nack, wr_nack;

	i2c_host_ctrl i_ctrl (
		.clk            (clk),
		.nrst           (nrst),
		.control_word_i (control_word_i),
		.data_word_i    (data_word_i),
		.rd_req_i       (rd_req),
		.wr_req_i       (wr_req),
		.rd_fin_i       (rd_fin),
		.wr_fin_i       (wr_fin),
		.rd_nack_i      (rd_nack),
		.wr_nack_i      (wr_nack),
		.rd_go_o        (rd_go),
		.wr_go_o        (wr_go),
		.cmd_o          (cmd),
		.wb_o           (wb_o),
		.done_o         (done_o),
		.busy_o         (busy_o),
		.nack_o         (nack_o)
	);

	// core read data and ack go to both sides
	i2c_read_seq i_rd_seq (
		.clk      (clk),
		.nrst     (nrst),
		.go_i     (rd_go),
		.cmd_i    (cmd),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i),
		.wb_o     (rd_req),
		.fin_o    (rd_fin),
		.nack_o   (rd_nack)
	);

	i2c_write_seq i_wr_seq (
		.clk      (clk),
		.nrst     (nrst),
		.go_i     (wr_go),
		.cmd_i    (cmd),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i),
		.wb_o     (wr_req),
		.fin_o    (wr_fin),
		.nack_o   (wr_nack)
	);

endmodule

//--- sim/tb_clkgen.sv
module tb_clkgen (
	output logic clk_o,
	output logic nrst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD  = 10; // 20 ns clock
	localparam int RESET_CYCLES = 3;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// release a little after the edge, like other stimulus
	initial begin
		nrst_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#2;
		nrst_o = 1'b1;
	end

endmodule

//--- sim/i2c_core_model.sv
`include "i2c_host_consts.svh"

module i2c_core_model import i2c_host_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  wb_req_t     wb_i,
	input  logic [2:0]  nack_byte_i, // 1-based byte that misses its ack or 0
	output logic [7:0]  wb_dat_o = 8'h00,
	output logic        wb_ack_o = 1'b0,
	output logic        log_vld_o = 1'b0, // one pulse per non-status access
	output logic [11:0] log_acc_o   // {adr, we, dat}
);
	timeunit 1ns;
	timeprecision 1ps;

	integer     seed = 32'h68e8c11a;
	logic       pending;  // strobe seen and ack still due
	logic [1:0] wait_cnt;
	wb_req_t    acc;      // access being served
	logic [2:0] byte_idx; // commands since the address write
	logic [1:0] poll_idx; // status polls since the last command

	always @(posedge clk) begin
		wb_req_t     cur;
		logic        rst_seen;
		logic [31:0] rnd;
		logic [7:0]  st;
		cur      = wb_i; // values before the DUT updates
		rst_seen = !nrst;
		#2;
		wb_ack_o  = 1'b0;
		log_vld_o = 1'b0;
		if (rst_seen) begin
			pending  = 1'b0;
			wait_cnt = 2'd0;
			byte_idx = 3'd0;
			poll_idx = 2'd0;
			wb_dat_o = 8'h00;
			log_acc_o = 12'h000;
		end else begin
			if (pending) begin
				if (wait_cnt == 2'd0) begin
					pending  = 1'b0;
					wb_ack_o = 1'b1;
					wb_dat_o = 8'h00;
					if (acc.we && acc.adr == `I2C_REG_ADDR)
						byte_idx = 3'd0; // new transaction
					else if (acc.we && acc.adr == `I2C_REG_CMD
						&& acc.dat != `I2C_CMD_STOP) begin
						byte_idx = byte_idx + 3'd1; // start, read or write starts a byte
						poll_idx = 2'd0;
					end else if (!acc.we && acc.adr == `I2C_REG_STATUS) begin
						st = 8'h00;
						// busy low for one poll, high for two, then low
						st[`I2C_ST_BUSY] = (poll_idx == 2'd1) || (poll_idx == 2'd2);
						st[`I2C_ST_NACK] = (poll_idx == 2'd0) && (nack_byte_i != 3'd0)
							&& (byte_idx == nack_byte_i);
						wb_dat_o = st;
						if (poll_idx != 2'd3)
							poll_idx = poll_idx + 2'd1;
					end else if (!acc.we)
						wb_dat_o = 8'ha5; // read fifo byte that the DUT drops
				end else
					wait_cnt = wait_cnt - 2'd1;
			end
			if (cur.stb) begin
				rnd      = $random(seed);
				wait_cnt = rnd[1:0]; // ack 1 to 4 cycles later
				pending  = 1'b1;
				acc      = cur;
				if (cur.adr != `I2C_REG_STATUS) begin
					log_vld_o = 1'b1;
					log_acc_o = {cur.adr, cur.we, cur.dat};
				end
			end
		end
	end

endmodule

//--- sim/i2c_main_controller_checker.sv
module i2c_main_controller_checker import i2c_host_pkg::*; (
	input logic    clk,
	input logic    nrst,
	input wb_req_t wb_i,
	input logic    wb_ack_i,
	input logic    done_i,
	input logic    busy_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int   fail_cnt = 0; // read by the testbench summary
	logic outstanding;  // strobe given, ack still due

	always_ff @(posedge clk) begin
		if (!nrst)
			outstanding <= 1'b0;
		else
			outstanding <= (outstanding && !wb_ack_i) || wb_i.stb;
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!nrst)
		wb_i.stb |-> wb_i.cyc)
	else begin
		$error("strobe outside of a bus cycle");
		fail_cnt++;
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!nrst)
		wb_i.stb |-> !outstanding)
	else begin
		$error("second strobe before the ack of the first");
		fail_cnt++;
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!nrst)
		done_i |=> !done_i)
	else begin
		$error("done_o longer than one cycle");
		fail_cnt++;
	end

	a_busy_done: assert property (@(posedge clk) disable iff (!nrst)
		!(busy_i && done_i))
	else begin
		$error("busy_o and done_o high together");
		fail_cnt++;
	end

endmodule

//--- sim/tb_i2c_main_controller.sv
`include "i2c_host_consts.svh"

module tb_i2c_main_controller import i2c_host_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// about 130 accesses with polls at up to 6 cycles of 20 ns each
	// plus reset and the idle watches
	localparam int WATCHDOG_NS  = 20000;
	localparam int DONE_TIMEOUT = 400; // cycles for one command

	logic        clk, nrst;
	logic [31:0] control_word, data_word;
	logic [7:0]  wb_dat;
	logic        wb_ack;
	wb_req_t     wb;
	logic        done, busy, nack;
	logic [2:0]  nack_byte;
	logic        log_vld;
	logic [11:0] log_acc;
	logic [11:0] acc_q[$]; // accesses seen by the core model
	logic [11:0] exp_q[$];
	int          errors;

	tb_clkgen i_clkgen (.clk_o(clk), .nrst_o(nrst));

	i2c_main_controller i_dut (
		.clk            (clk),
		.nrst           (nrst),
		.control_word_i (control_word),
		.data_word_i    (data_word),
		.wb_dat_i       (wb_dat),
		.wb_ack_i       (wb_ack),
		.wb_o           (wb),
		.done_o         (done),
		.busy_o         (busy),
		.nack_o         (nack)
	);

	i2c_core_model i_core (
		.clk         (clk),
		.nrst        (nrst),
		.wb_i        (wb),
		.nack_byte_i (nack_byte),
		.wb_dat_o    (wb_dat),
		.wb_ack_o    (wb_ack),
		.log_vld_o   (log_vld),
		.log_acc_o   (log_acc)
	);

	bind i2c_main_controller i2c_main_controller_checker i_checker (
		.clk(clk), .nrst(nrst), .wb_i(wb_o), .wb_ack_i(wb_ack_i),
		.done_i(done_o), .busy_i(busy_o)
	);

	always @(posedge clk)
		if (log_vld)
			acc_q.push_back(log_acc);

	function automatic logic [31:0] make_cw(input logic rd, input logic wr,
		input logic [6:0] addr, input int len);
		logic [31:0] w;
		w = '0;
		w[`CW_START] = 1'b1;
		w[`CW_READ]  = rd;
		w[`CW_WRITE] = wr;
		w[`CW_ADDR_MSB:`CW_ADDR_LSB] = addr;
		w[`CW_LEN_MSB:`CW_LEN_LSB]   = len[3:0];
		return w;
	endfunction

	task automatic expect_acc(input logic [2:0] adr, input logic we, input logic [7:0] dat);
		exp_q.push_back({adr, we, dat});
	endtask

	task automatic expect_write(input logic [6:0] addr, input int len, input logic [31:0] data);
		expect_acc(`I2C_REG_ADDR, 1'b1, {1'b0, addr});
		for (int i = 0; i < len; i++)
			expect_acc(`I2C_REG_DATA, 1'b1, data[8*i +: 8]); // low byte first
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_START_WRITE);
		for (int i = 1; i < len; i++)
			expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_WRITE);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_STOP);
	endtask

	task automatic expect_read(input logic [6:0] addr, input int len);
		expect_acc(`I2C_REG_ADDR, 1'b1, {1'b0, addr});
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_START_READ);
		for (int i = 1; i < len; i++)
			expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_READ);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_STOP);
		for (int i = 0; i < len; i++)
			expect_acc(`I2C_REG_DATA, 1'b0, 8'h00); // fifo drain
	endtask

	task automatic start_test(input logic [2:0] nack_at);
		acc_q.delete();
		exp_q.delete();
		nack_byte = nack_at;
	endtask

	// start held one cycle and dropped so the command is not repeated
	task automatic send_cmd(input logic [31:0] cw, input logic [31:0] dw);
		@(posedge clk);
		#2;
		control_word = cw;
		data_word    = dw;
		@(posedge clk);
		#2;
		control_word = '0;
	endtask

	task automatic wait_done(input string what);
		int   n;
		logic seen;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < DONE_TIMEOUT) begin
			@(negedge clk);
			seen = done;
			n++;
		end
		assert (seen) else begin
			$display("%s: no done pulse within %0d cycles", what, DONE_TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_accesses(input string what);
		assert (acc_q.size() == exp_q.size()) else begin
			$display("[ERROR] %0t %s wb_o access count: got %0d expected %0d",
				$time, what, acc_q.size(), exp_q.size());
			errors++;
		end
		for (int i = 0; i < exp_q.size() && i < acc_q.size(); i++)
			assert (acc_q[i] == exp_q[i]) else begin
				// adr we dat of each access
				$display("[ERROR] %0t %s wb_o access %0d: got %0d %b %h expected %0d %b %h",
					$time, what, i, acc_q[i][11:9], acc_q[i][8], acc_q[i][7:0],
					exp_q[i][11:9], exp_q[i][8], exp_q[i][7:0]);
				errors++;
			end
	endtask

	// no busy and no done for a number of cycles
	task automatic watch_quiet(input int cycles, input string what);
		int done_cnt;
		int busy_cnt;
		done_cnt = 0;
		busy_cnt = 0;
		for (int n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (done)
				done_cnt++;
			if (busy)
				busy_cnt++;
		end
		assert (done_cnt == 0 && busy_cnt == 0) else begin
			$display("%s: command not ignored, busy for %0d and done for %0d cycles",
				what, busy_cnt, done_cnt);
			errors++;
		end
	endtask

	task automatic check_idle_outputs();
		check_bit("wb_o.stb", wb.stb, 1'b0);
		check_bit("wb_o.cyc", wb.cyc, 1'b0);
		check_bit("wb_o.we", wb.we, 1'b0);
		check_bit("done_o", done, 1'b0);
		check_bit("busy_o", busy, 1'b0);
		check_bit("nack_o", nack, 1'b0);
	endtask

	task automatic test_reset();
		@(negedge clk); // first edge has already reset the flops
		while (!nrst) begin
			check_idle_outputs();
			@(negedge clk);
		end
		check_idle_outputs();
	endtask

	task automatic test_write(input logic [6:0] addr, input int len, input logic [31:0] data);
		start_test(3'd0);
		expect_write(addr, len, data);
		send_cmd(make_cw(1'b0, 1'b1, addr, len), data);
		wait_done($sformatf("write of %0d bytes", len));
		check_bit("nack_o", nack, 1'b0);
		check_accesses($sformatf("write of %0d bytes", len));
	endtask

	task automatic test_read(input logic [6:0] addr, input int len);
		start_test(3'd0);
		expect_read(addr, len);
		send_cmd(make_cw(1'b1, 1'b0, addr, len), 32'h0);
		wait_done($sformatf("read of %0d bytes", len));
		check_bit("nack_o", nack, 1'b0);
		check_accesses($sformatf("read of %0d bytes", len));
	endtask

	// slave drops out on byte 2 of 3
	task automatic test_write_nack();
		start_test(3'd2);
		expect_acc(`I2C_REG_ADDR, 1'b1, 8'h3c);
		expect_acc(`I2C_REG_DATA, 1'b1, 8'h99);
		expect_acc(`I2C_REG_DATA, 1'b1, 8'h88);
		expect_acc(`I2C_REG_DATA, 1'b1, 8'h77);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_START_WRITE);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_WRITE);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_STOP);
		send_cmd(make_cw(1'b0, 1'b1, 7'h3c, 3), 32'h0077_8899);
		wait_done("write with nack");
		check_bit("nack_o", nack, 1'b1);
		check_accesses("write with nack");
		nack_byte = 3'd0;
		@(negedge clk);
		check_bit("nack_o", nack, 1'b1); // level holds past done
		test_write(7'h3d, 1, 32'h0000_0042);
	endtask

	task automatic test_read_nack();
		start_test(3'd1);
		expect_acc(`I2C_REG_ADDR, 1'b1, 8'h2e);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_START_READ);
		expect_acc(`I2C_REG_CMD, 1'b1, `I2C_CMD_STOP);
		send_cmd(make_cw(1'b1, 1'b0, 7'h2e, 2), 32'h0);
		wait_done("read with nack");
		check_bit("nack_o", nack, 1'b1);
		check_accesses("read with nack");
		nack_byte = 3'd0;
	endtask

	task automatic test_ignore_no_dir();
		start_test(3'd0);
		@(posedge clk);
		#2;
		control_word = make_cw(1'b0, 1'b0, 7'h11, 1); // start alone
		watch_quiet(40, "start without read or write");
		@(posedge clk);
		#2;
		control_word = '0;
		check_accesses("start without read or write");
	endtask

	task automatic test_ignore_busy();
		start_test(3'd0);
		expect_write(7'h44, 1, 32'h0000_00e1);
		send_cmd(make_cw(1'b0, 1'b1, 7'h44, 1), 32'h0000_00e1);
		@(posedge clk);
		#2;
		control_word = make_cw(1'b1, 1'b0, 7'h45, 2);
		repeat (3) begin
			@(negedge clk);
			check_bit("busy_o", busy, 1'b1);
		end
		@(posedge clk);
		#2;
		control_word = '0; // gone well before done
		wait_done("write with a second command while busy");
		check_bit("nack_o", nack, 1'b0);
		watch_quiet(30, "second command while busy");
		check_accesses("second command while busy");
	endtask

	initial begin
		control_word = '0;
		data_word    = '0;
		nack_byte    = 3'd0;
		errors       = 0;
		test_reset();
		test_write(7'h50, 1, 32'h0000_00a7);
		test_write(7'h51, 2, 32'h0000_b3c4);
		test_write(7'h52, 3, 32'h00d5_e6f7);
		test_write(7'h53, 4, 32'h1829_3a4b);
		test_read(7'h21, 1);
		test_read(7'h22, 3);
		test_write_nack();
		test_read_nack();
		test_ignore_no_dir();
		test_ignore_busy();
		$display("errors: %0d in checks, %0d in protocol assertions",
			errors, i_dut.i_checker.fail_cnt);
		if (errors == 0 && i_dut.i_checker.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		#WATCHDOG_NS;
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- i2c_main_controller.f
+incdir+rtl
rtl/i2c_host_pkg.sv
rtl/i2c_read_seq.sv
rtl/i2c_write_seq.sv
rtl/i2c_host_ctrl.sv
rtl/i2c_main_controller.sv
sim/tb_clkgen.sv
sim/i2c_core_model.sv
sim/i2c_main_controller_checker.sv
sim/tb_i2c_main_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

TOP=tb_i2c_main_controller
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$TOP" -f i2c_main_controller.f -o "V$TOP"

"./obj_dir/V$TOP" +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi
echo "simulation finished without failures"
